// File: sources.f
+incdir+hw
hw/sdio_dc_pkg.sv
hw/sdio_func_router.sv
hw/sdio_xfer_seq.sv
hw/sdio_cmd_byte_port.sv
hw/sdio_data_ctrl.sv
dv/tb_sdio_data_ctrl.sv

// File: Makefile
# Verilator build and run of the SDIO data controller testbench

SIM := obj_dir/Vtb_sdio_data_ctrl

.PHONY: all run clean

all: $(SIM)

$(SIM): sources.f hw/sdio_dc_params.svh $(wildcard hw/*.sv) $(wildcard dv/*.sv)
	verilator --binary --assert -Wno-fatal -f sources.f \
		--top-module tb_sdio_data_ctrl -Mdir obj_dir

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: dv/tb_sdio_data_ctrl.sv
// Testbench for the SDIO data-path controller
// PHY and target models answer the DUT handshakes, while concurrent
// assertions check routing, counts, address and completion

`timescale 1ns/1ps
`default_nettype none

`include "sdio_dc_params.svh"

module tb_sdio_data_ctrl;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic i_write_flg = 1'b0;
  logic i_block_mode_flg = 1'b0;
  logic [12:0] i_data_cnt = '0;
  logic i_inc_addr_flg = 1'b0;
  logic [17:0] i_cmd_address = '0;
  logic i_activate = 1'b0;
  logic i_cmd_bus_sel = 1'b0;
  logic i_mem_sel = 1'b0;
  logic [3:0] i_func_sel = '0;
  logic [7:0] i_cmd_wr_data = '0;
  logic i_data_phy_wr_stb = 1'b0;
  logic [7:0] i_data_phy_wr_data = '0;
  logic i_data_phy_hst_rdy = 1'b0;
  logic i_data_phy_finished = 1'b0;
  logic [8:0] i_tgt_rd_stb = '0;
  logic [71:0] i_tgt_rd_data = '0;
  logic [8:0] i_tgt_com_rdy = '1;
  logic [143:0] i_tgt_block_size = '0;

  wire [7:0] o_cmd_rd_data;
  wire o_data_phy_rd_stb;
  wire [7:0] o_data_phy_rd_data;
  wire o_data_phy_com_rdy;
  wire o_data_phy_activate;
  wire [8:0] o_tgt_wr_stb;
  wire [71:0] o_tgt_wr_data;
  wire [8:0] o_tgt_hst_rdy;
  wire [8:0] o_tgt_activate;
  wire o_data_bus_busy;
  wire [12:0] o_total_data_cnt;
  wire [17:0] o_address;
  wire o_finished;

  // Expected values of the running test
  logic [3:0] exp_tgt = '0;
  logic [12:0] exp_total = '0;
  logic [12:0] exp_strobes = '0;
  logic [17:0] exp_addr_end = '0;
  logic chk_idle = 1'b0;
  logic chk_cooldown = 1'b0;
  logic phy_en = 1'b0;

  logic [12:0] strobe_cnt = '0;
  logic [7:0] last_rd_byte = '0;
  logic [7:0] sent_byte = '0;
  logic phy_act_q = 1'b0;
  logic saw_cd_drop = 1'b0;
  logic [31:0] lfsr = 32'h924d;

  sdio_data_ctrl UUT (.*);

  always #50 clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      b = {b[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return b;
  endfunction

  // Targets hand over one read byte per host-ready pulse
  always @(posedge clk) begin : tgt_model
    logic [7:0] b;
    for (int t = 0; t < 9; t++) begin
      if (!rst && !i_write_flg && o_tgt_hst_rdy[t] && !i_tgt_rd_stb[t]) begin
        b = rand_byte();
        i_tgt_rd_stb[t] <= 1'b1;
        i_tgt_rd_data[t*8 +: 8] <= b;
        last_rd_byte <= b;
      end else begin
        i_tgt_rd_stb[t] <= 1'b0;
      end
    end
  end

  // PHY sends a write byte whenever the target is ready
  always @(posedge clk) begin : phy_model
    logic [7:0] b;
    if (phy_en && i_write_flg && !i_cmd_bus_sel && o_data_phy_com_rdy && !i_data_phy_wr_stb) begin
      b = rand_byte();
      i_data_phy_wr_stb <= 1'b1;
      i_data_phy_wr_data <= b;
      sent_byte <= b;
    end else begin
      i_data_phy_wr_stb <= 1'b0;
    end
  end

  // Strobe count and cooldown tracking per activation
  always @(posedge clk) begin
    phy_act_q <= o_data_phy_activate;
    if (!i_activate) begin
      strobe_cnt <= '0;
      saw_cd_drop <= 1'b0;
    end else begin
      if ((|o_tgt_wr_stb) || (|i_tgt_rd_stb)) begin
        strobe_cnt <= strobe_cnt + 1'b1;
      end
      if (phy_act_q && !o_data_phy_activate && strobe_cnt == 13'd3 && !o_finished) begin
        saw_cd_drop <= 1'b1;
      end
    end
  end

  a_idle: assert property (@(posedge clk) chk_idle |-> !o_finished && !o_data_bus_busy &&
    !o_data_phy_activate && o_tgt_wr_stb == '0 && o_tgt_hst_rdy == '0 && o_tgt_activate == '0)
    else stop_run($sformatf("ERR %0t: outputs active after reset", $time));

  a_wr_route: assert property (@(posedge clk) (|o_tgt_wr_stb) |->
    o_tgt_wr_stb == (9'd1 << exp_tgt) && o_tgt_wr_data[exp_tgt*8 +: 8] == sent_byte)
    else stop_run($sformatf("ERR %0t: write strobe %h misrouted", $time, o_tgt_wr_stb));

  a_rd_route: assert property (@(posedge clk) o_data_phy_rd_stb |->
    i_tgt_rd_stb == (9'd1 << exp_tgt) && o_data_phy_rd_data == last_rd_byte)
    else stop_run($sformatf("ERR %0t: PHY read byte %h wrong", $time, o_data_phy_rd_data));

  a_cmd_rd_route: assert property (@(posedge clk) (i_cmd_bus_sel && (|i_tgt_rd_stb)) |->
    i_tgt_rd_stb == (9'd1 << exp_tgt) && o_cmd_rd_data == last_rd_byte)
    else stop_run($sformatf("ERR %0t: command read byte %h wrong", $time, o_cmd_rd_data));

  a_total: assert property (@(posedge clk) o_data_bus_busy |-> o_total_data_cnt == exp_total)
    else stop_run($sformatf("ERR %0t: total %0d, expected %0d", $time, o_total_data_cnt,
      exp_total));

  a_strobe_limit: assert property (@(posedge clk) strobe_cnt <= exp_strobes)
    else stop_run($sformatf("ERR %0t: too many strobes %0d", $time, strobe_cnt));

  a_finish_cnt: assert property (@(posedge clk) o_finished |-> strobe_cnt == exp_strobes &&
    o_address == exp_addr_end)
    else stop_run($sformatf("ERR %0t: finished with %0d strobes, address %h", $time,
      strobe_cnt, o_address));

  a_cooldown: assert property (@(posedge clk) (chk_cooldown && o_finished) |-> saw_cd_drop)
    else stop_run($sformatf("ERR %0t: PHY activate held through cooldown", $time));

  a_cmd_quiet: assert property (@(posedge clk) i_cmd_bus_sel |-> !o_data_phy_rd_stb &&
    o_data_phy_rd_data == 8'h00 && !o_data_phy_com_rdy && !o_data_phy_activate)
    else stop_run($sformatf("ERR %0t: PHY outputs active in command mode", $time));

  task automatic start_xfer(input logic wr, input logic blk, input logic [12:0] cnt,
                            input logic inc, input logic cmd, input logic mem,
                            input logic [3:0] func);
    @(posedge clk);
    i_write_flg <= wr;
    i_block_mode_flg <= blk;
    i_data_cnt <= cnt;
    i_inc_addr_flg <= inc;
    i_cmd_bus_sel <= cmd;
    i_mem_sel <= mem;
    i_func_sel <= func;
    i_activate <= 1'b1;
  endtask

  task automatic wait_finished(input logic level);
    int n;
    n = 0;
    while (o_finished !== level && n < 5000) begin
      @(posedge clk);
      n++;
    end
    if (o_finished !== level) begin
      stop_run("Timed out waiting for the finished flag to change");
    end
  endtask

  task automatic wait_busy();
    int n;
    n = 0;
    while (o_data_bus_busy !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (o_data_bus_busy !== 1'b1) begin
      stop_run("Timed out waiting for the data bus to become busy");
    end
  endtask

  task automatic end_xfer();
    @(posedge clk);
    i_activate <= 1'b0;
    wait_finished(1'b0);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    i_data_phy_hst_rdy <= 1'b1;
    // Target 1 uses 3-byte blocks
    i_tgt_block_size[16 +: 16] <= 16'd3;
    i_cmd_address <= 18'h100;
    @(posedge clk);
    chk_idle <= 1'b1;
    repeat (4) @(posedge clk);
    chk_idle <= 1'b0;

    // Byte-mode PHY write to function 2
    phy_en <= 1'b1;
    exp_tgt <= 4'd2;
    exp_total <= 13'd4;
    exp_strobes <= 13'd4;
    exp_addr_end <= 18'h104;
    start_xfer(1'b1, 1'b0, 13'd4, 1'b1, 1'b0, 1'b0, 4'd2);
    wait_finished(1'b1);
    end_xfer();

    // Count of 0 in byte mode
    phy_en <= 1'b0;
    exp_total <= 13'd512;
    exp_strobes <= 13'd0;
    exp_addr_end <= 18'h100;
    start_xfer(1'b1, 1'b0, 13'd0, 1'b0, 1'b0, 1'b0, 4'd2);
    wait_busy();
    repeat (3) @(posedge clk);
    end_xfer();

    // Memory select overrides the function number
    exp_tgt <= 4'd8;
    exp_total <= 13'd2;
    exp_strobes <= 13'd2;
    start_xfer(1'b0, 1'b0, 13'd2, 1'b0, 1'b0, 1'b1, 4'd3);
    wait_finished(1'b1);
    end_xfer();

    // Two read blocks of 3 bytes from function 1
    exp_tgt <= 4'd1;
    exp_total <= 13'd3;
    exp_strobes <= 13'd6;
    chk_cooldown <= 1'b1;
    start_xfer(1'b0, 1'b1, 13'd2, 1'b0, 1'b0, 1'b0, 4'd1);
    wait_finished(1'b1);
    end_xfer();
    chk_cooldown <= 1'b0;

    // Command-bus single-byte write to function 5
    exp_tgt <= 4'd5;
    exp_total <= 13'd1;
    exp_strobes <= 13'd1;
    i_cmd_wr_data <= 8'h5a;
    sent_byte <= 8'h5a;
    start_xfer(1'b1, 1'b0, 13'd1, 1'b0, 1'b1, 1'b0, 4'd5);
    wait_finished(1'b1);
    repeat (3) @(posedge clk);
    end_xfer();

    // Command-bus single-byte read from function 4
    exp_tgt <= 4'd4;
    start_xfer(1'b0, 1'b0, 13'd1, 1'b0, 1'b1, 1'b0, 4'd4);
    wait_finished(1'b1);
    end_xfer();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/sdio_data_ctrl.sv
// SDIO data-path controller
// Connects the data PHY and the command layer's byte path to the
// CIA, functions 1 to 7 and memory, with a transfer sequencer for
// byte and block transfers

`timescale 1ns/1ps
`default_nettype none

module sdio_data_ctrl (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_write_flg,
  input  wire                       i_block_mode_flg,
  input  sdio_dc_pkg::xfer_cnt_t    i_data_cnt,
  input  wire                       i_inc_addr_flg,
  input  sdio_dc_pkg::sdio_addr_t   i_cmd_address,
  input  wire                       i_activate,
  input  wire                       i_cmd_bus_sel,
  input  wire                       i_mem_sel,
  input  sdio_dc_pkg::tgt_sel_t     i_func_sel,
  // Command bus
  input  sdio_dc_pkg::byte_t        i_cmd_wr_data,
  output sdio_dc_pkg::byte_t        o_cmd_rd_data,
  // Data PHY
  input  wire                       i_data_phy_wr_stb,
  input  sdio_dc_pkg::byte_t        i_data_phy_wr_data,
  output logic                      o_data_phy_rd_stb,
  output sdio_dc_pkg::byte_t        o_data_phy_rd_data,
  input  wire                       i_data_phy_hst_rdy,
  output logic                      o_data_phy_com_rdy,
  output logic                      o_data_phy_activate,
  input  wire                       i_data_phy_finished,
  // Targets, indexed by target number
  output sdio_dc_pkg::tgt_vec_t     o_tgt_wr_stb,
  output sdio_dc_pkg::tgt_bytes_t   o_tgt_wr_data,
  input  sdio_dc_pkg::tgt_vec_t     i_tgt_rd_stb,
  input  sdio_dc_pkg::tgt_bytes_t   i_tgt_rd_data,
  output sdio_dc_pkg::tgt_vec_t     o_tgt_hst_rdy,
  input  sdio_dc_pkg::tgt_vec_t     i_tgt_com_rdy,
  output sdio_dc_pkg::tgt_vec_t     o_tgt_activate,
  input  sdio_dc_pkg::tgt_bsize_t   i_tgt_block_size,
  // Status
  output logic                      o_data_bus_busy,
  output sdio_dc_pkg::xfer_cnt_t    o_total_data_cnt,
  output sdio_dc_pkg::sdio_addr_t   o_address,
  output logic                      o_finished
);

  logic                      cmd_wr_stb;
  logic                      cmd_hst_rdy;
  logic                      cmd_rd_stb;
  logic                      com_rdy;
  logic                      seq_rdy;
  logic                      phy_activate;
  logic                      xfer_stb;
  logic                      src_rdy;
  sdio_dc_pkg::block_size_t  block_size;

  sdio_func_router u_router (
    .i_cmd_bus_sel(i_cmd_bus_sel), .i_mem_sel(i_mem_sel), .i_func_sel(i_func_sel),
    .i_activate(i_activate), .i_cmd_wr_stb(cmd_wr_stb), .i_cmd_wr_data(i_cmd_wr_data),
    .i_cmd_hst_rdy(cmd_hst_rdy), .o_cmd_rd_stb(cmd_rd_stb), .o_cmd_rd_data(o_cmd_rd_data),
    .i_phy_wr_stb(i_data_phy_wr_stb), .i_phy_wr_data(i_data_phy_wr_data),
    .i_phy_hst_rdy(i_data_phy_hst_rdy), .i_phy_activate(phy_activate),
    .o_phy_rd_stb(o_data_phy_rd_stb), .o_phy_rd_data(o_data_phy_rd_data),
    .o_phy_com_rdy(o_data_phy_com_rdy), .o_phy_activate(o_data_phy_activate),
    .i_seq_rdy(seq_rdy), .o_tgt_wr_stb(o_tgt_wr_stb), .o_tgt_wr_data(o_tgt_wr_data),
    .i_tgt_rd_stb(i_tgt_rd_stb), .i_tgt_rd_data(i_tgt_rd_data),
    .o_tgt_hst_rdy(o_tgt_hst_rdy), .i_tgt_com_rdy(i_tgt_com_rdy),
    .o_tgt_activate(o_tgt_activate), .i_tgt_block_size(i_tgt_block_size),
    .o_xfer_stb(xfer_stb), .o_src_rdy(src_rdy), .o_com_rdy(com_rdy),
    .o_block_size(block_size)
  );

  sdio_xfer_seq u_seq (
    .clk(clk), .rst(rst), .i_activate(i_activate), .i_write_flg(i_write_flg),
    .i_block_mode_flg(i_block_mode_flg), .i_data_cnt(i_data_cnt),
    .i_inc_addr_flg(i_inc_addr_flg), .i_cmd_address(i_cmd_address),
    .i_src_rdy(src_rdy), .i_xfer_stb(xfer_stb), .i_block_size(block_size),
    .i_phy_finished(i_data_phy_finished), .o_seq_rdy(seq_rdy),
    .o_phy_activate(phy_activate), .o_busy(o_data_bus_busy),
    .o_total_data_cnt(o_total_data_cnt), .o_address(o_address), .o_finished(o_finished)
  );

  sdio_cmd_byte_port u_byte_port (
    .clk(clk), .rst(rst), .i_cmd_bus_sel(i_cmd_bus_sel), .i_activate(i_activate),
    .i_write_flg(i_write_flg), .i_com_rdy(com_rdy), .i_rd_stb(cmd_rd_stb),
    .o_wr_stb(cmd_wr_stb), .o_hst_rdy(cmd_hst_rdy)
  );

endmodule

`default_nettype wire

// File: hw/sdio_cmd_byte_port.sv
// SDIO command byte port
// Moves a single byte between the command layer and the selected
// target: one write strobe or one accepted read per activation

`timescale 1ns/1ps
`default_nettype none

module sdio_cmd_byte_port (
  input  wire   clk,
  input  wire   rst,
  input  wire   i_cmd_bus_sel,
  input  wire   i_activate,
  input  wire   i_write_flg,
  input  wire   i_com_rdy,
  input  wire   i_rd_stb,
  output logic  o_wr_stb,
  output logic  o_hst_rdy
);

  sdio_dc_pkg::byte_port_state_e  state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= sdio_dc_pkg::BP_IDLE;
      o_wr_stb  <= 1'b0;
      o_hst_rdy <= 1'b0;
    end else begin
      o_wr_stb <= 1'b0;
      case (state)
        sdio_dc_pkg::BP_IDLE: begin
          o_hst_rdy <= 1'b0;
          if (i_cmd_bus_sel && i_activate) begin
            o_hst_rdy <= 1'b1;
            state <= i_write_flg ? sdio_dc_pkg::BP_WRITE : sdio_dc_pkg::BP_READ;
          end
        end
        sdio_dc_pkg::BP_WRITE: begin
          if (i_com_rdy) begin
            o_wr_stb  <= 1'b1;
            o_hst_rdy <= 1'b0;
            state     <= sdio_dc_pkg::BP_DONE;
          end
        end
        // Host-ready held until the target hands over its byte
        sdio_dc_pkg::BP_READ: begin
          if (i_rd_stb) begin
            o_hst_rdy <= 1'b0;
            state     <= sdio_dc_pkg::BP_DONE;
          end
        end
        // DONE holds until activate drops
        default: o_hst_rdy <= 1'b0;
      endcase
      if (!i_activate) begin
        o_hst_rdy <= 1'b0;
        state     <= sdio_dc_pkg::BP_IDLE;
      end
    end
  end

  a_single_wr_stb: assert property (@(posedge clk) disable iff (rst)
    o_wr_stb |=> !o_wr_stb)
    else $error("ERR byte port: back to back write strobes");

endmodule

`default_nettype wire

// File: hw/sdio_xfer_seq.sv
// SDIO transfer sequencer
// Counts bytes of a byte-mode or block-mode transfer, steps the
// address, waits for the PHY between write blocks and holds off
// between read blocks for a fixed cooldown

`timescale 1ns/1ps
`default_nettype none

`include "sdio_dc_params.svh"

module sdio_xfer_seq #(
  parameter int READ_COOLDOWN = `SDIO_DC_READ_COOLDOWN
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_activate,
  input  wire                       i_write_flg,
  input  wire                       i_block_mode_flg,
  input  sdio_dc_pkg::xfer_cnt_t    i_data_cnt,
  input  wire                       i_inc_addr_flg,
  input  sdio_dc_pkg::sdio_addr_t   i_cmd_address,
  input  wire                       i_src_rdy,
  input  wire                       i_xfer_stb,
  input  sdio_dc_pkg::block_size_t  i_block_size,
  input  wire                       i_phy_finished,
  output logic                      o_seq_rdy,
  output logic                      o_phy_activate,
  output logic                      o_busy,
  output sdio_dc_pkg::xfer_cnt_t    o_total_data_cnt,
  output sdio_dc_pkg::sdio_addr_t   o_address,
  output logic                      o_finished
);

  localparam int CD_W = $clog2(READ_COOLDOWN + 1);

  sdio_dc_pkg::xfer_state_e  state;
  sdio_dc_pkg::xfer_cnt_t    byte_cnt;
  sdio_dc_pkg::xfer_cnt_t    blk_cnt;
  sdio_dc_pkg::xfer_cnt_t    blk_total;
  logic                      continuous;
  logic [CD_W-1:0]           cd_cnt;
  logic                      last_blk;

  assign o_busy   = (state == sdio_dc_pkg::XFER_ACTIVE);
  // Continuous block transfers run until activate drops
  assign last_blk = !continuous && (blk_cnt >= blk_total);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= sdio_dc_pkg::XFER_IDLE;
      o_seq_rdy        <= 1'b0;
      o_phy_activate   <= 1'b0;
      o_finished       <= 1'b0;
      o_total_data_cnt <= '0;
      byte_cnt         <= '0;
      blk_cnt          <= '0;
      continuous       <= 1'b0;
    end else begin
      case (state)
        sdio_dc_pkg::XFER_IDLE: begin
          o_seq_rdy        <= 1'b0;
          o_phy_activate   <= 1'b0;
          o_finished       <= 1'b0;
          o_total_data_cnt <= '0;
          byte_cnt         <= '0;
          blk_cnt          <= '0;
          blk_total        <= i_data_cnt;
          continuous       <= i_block_mode_flg && (i_data_cnt == '0);
          o_address        <= i_cmd_address;
          if (i_activate) begin
            state <= sdio_dc_pkg::XFER_CONFIG;
          end
        end
        sdio_dc_pkg::XFER_CONFIG: begin
          byte_cnt <= '0;
          if (i_block_mode_flg) begin
            o_total_data_cnt <= i_block_size[`SDIO_DC_CNT_W-1:0];
            if (!continuous) begin
              blk_cnt <= blk_cnt + 1'b1;
            end
          end else if (i_data_cnt == '0) begin
            o_total_data_cnt <= sdio_dc_pkg::xfer_cnt_t'(`SDIO_DC_DEFAULT_BYTES);
          end else begin
            o_total_data_cnt <= i_data_cnt;
          end
          state <= sdio_dc_pkg::XFER_ACTIVE;
        end
        sdio_dc_pkg::XFER_ACTIVE: begin
          o_phy_activate <= 1'b1;
          if (byte_cnt == o_total_data_cnt) begin
            o_seq_rdy <= 1'b0;
            if (!i_block_mode_flg) begin
              o_phy_activate <= 1'b0;
              state          <= sdio_dc_pkg::XFER_DONE;
            end else if (i_write_flg) begin
              state <= sdio_dc_pkg::XFER_WAIT_PHY;
            end else begin
              // PHY released for the cooldown
              o_phy_activate <= 1'b0;
              cd_cnt         <= '0;
              state          <= sdio_dc_pkg::XFER_COOLDOWN;
            end
          end else if (i_src_rdy) begin
            o_seq_rdy <= 1'b1;
            if (i_xfer_stb) begin
              byte_cnt <= byte_cnt + 1'b1;
              if (i_inc_addr_flg) begin
                o_address <= o_address + 1'b1;
              end
              // Drop ready with the last byte so no extra strobe follows
              if (byte_cnt + 1'b1 == o_total_data_cnt) begin
                o_seq_rdy <= 1'b0;
              end
            end
          end
        end
        sdio_dc_pkg::XFER_WAIT_PHY: begin
          if (i_phy_finished) begin
            o_phy_activate <= 1'b0;
            state <= last_blk ? sdio_dc_pkg::XFER_DONE : sdio_dc_pkg::XFER_CONFIG;
          end
        end
        sdio_dc_pkg::XFER_COOLDOWN: begin
          if (cd_cnt == CD_W'(READ_COOLDOWN - 1)) begin
            state <= last_blk ? sdio_dc_pkg::XFER_DONE : sdio_dc_pkg::XFER_CONFIG;
          end else begin
            cd_cnt <= cd_cnt + 1'b1;
          end
        end
        sdio_dc_pkg::XFER_DONE: begin
          o_phy_activate <= 1'b0;
          o_finished     <= 1'b1;
        end
        default: state <= sdio_dc_pkg::XFER_IDLE;
      endcase

      // Cancel or end of transfer
      if (!i_activate) begin
        state          <= sdio_dc_pkg::XFER_IDLE;
        o_seq_rdy      <= 1'b0;
        o_phy_activate <= 1'b0;
        o_finished     <= 1'b0;
      end
    end
  end

  a_finished_in_done: assert property (@(posedge clk) disable iff (rst)
    o_finished |-> state == sdio_dc_pkg::XFER_DONE)
    else $error("ERR seq: finished outside DONE");

  a_cnt_in_range: assert property (@(posedge clk) disable iff (rst)
    byte_cnt <= o_total_data_cnt)
    else $error("ERR seq: byte count above total");

endmodule

`default_nettype wire

// File: hw/sdio_func_router.sv
// SDIO function router
// Decodes the selected target and steers write bytes, ready and
// activate from the active source (PHY or command byte port) to it,
// and its read bytes, ready and block size back to that source

`timescale 1ns/1ps
`default_nettype none

`include "sdio_dc_params.svh"

module sdio_func_router (
  input  wire                       i_cmd_bus_sel,
  input  wire                       i_mem_sel,
  input  sdio_dc_pkg::tgt_sel_t     i_func_sel,
  input  wire                       i_activate,
  input  wire                       i_cmd_wr_stb,
  input  sdio_dc_pkg::byte_t        i_cmd_wr_data,
  input  wire                       i_cmd_hst_rdy,
  output logic                      o_cmd_rd_stb,
  output sdio_dc_pkg::byte_t        o_cmd_rd_data,
  input  wire                       i_phy_wr_stb,
  input  sdio_dc_pkg::byte_t        i_phy_wr_data,
  input  wire                       i_phy_hst_rdy,
  input  wire                       i_phy_activate,
  output logic                      o_phy_rd_stb,
  output sdio_dc_pkg::byte_t        o_phy_rd_data,
  output logic                      o_phy_com_rdy,
  output logic                      o_phy_activate,
  input  wire                       i_seq_rdy,
  output sdio_dc_pkg::tgt_vec_t     o_tgt_wr_stb,
  output sdio_dc_pkg::tgt_bytes_t   o_tgt_wr_data,
  input  sdio_dc_pkg::tgt_vec_t     i_tgt_rd_stb,
  input  sdio_dc_pkg::tgt_bytes_t   i_tgt_rd_data,
  output sdio_dc_pkg::tgt_vec_t     o_tgt_hst_rdy,
  input  sdio_dc_pkg::tgt_vec_t     i_tgt_com_rdy,
  output sdio_dc_pkg::tgt_vec_t     o_tgt_activate,
  input  sdio_dc_pkg::tgt_bsize_t   i_tgt_block_size,
  output logic                      o_xfer_stb,
  output logic                      o_src_rdy,
  output logic                      o_com_rdy,
  output sdio_dc_pkg::block_size_t  o_block_size
);

  sdio_dc_pkg::tgt_sel_t  tgt_sel;
  logic                   tgt_valid;
  logic                   wr_stb;
  sdio_dc_pkg::byte_t     wr_data;
  logic                   hst_rdy;
  logic                   activate;
  logic                   rd_stb;
  sdio_dc_pkg::byte_t     rd_data;

  // Memory overrides the function number; 8 and up alone selects nothing
  assign tgt_sel   = i_mem_sel ? 4'(`SDIO_DC_MEM_TGT) : i_func_sel;
  assign tgt_valid = i_mem_sel || (i_func_sel < 4'(`SDIO_DC_MEM_TGT));

  // Source side
  assign wr_stb   = i_cmd_bus_sel ? i_cmd_wr_stb  : i_phy_wr_stb;
  assign wr_data  = i_cmd_bus_sel ? i_cmd_wr_data : i_phy_wr_data;
  assign activate = i_cmd_bus_sel ? i_activate    : i_phy_activate;
  // Byte port gates host-ready in command mode
  assign hst_rdy  = i_seq_rdy & (~i_cmd_bus_sel | i_cmd_hst_rdy);

  always_comb begin
    o_tgt_wr_stb   = '0;
    o_tgt_wr_data  = '0;
    o_tgt_hst_rdy  = '0;
    o_tgt_activate = '0;
    rd_stb         = 1'b0;
    rd_data        = '0;
    o_com_rdy      = 1'b0;
    o_block_size   = '0;
    if (tgt_valid) begin
      o_tgt_wr_stb[tgt_sel]        = wr_stb;
      o_tgt_wr_data[tgt_sel*8 +: 8] = wr_data;
      o_tgt_hst_rdy[tgt_sel]       = hst_rdy;
      o_tgt_activate[tgt_sel]      = activate;
      rd_stb                       = i_tgt_rd_stb[tgt_sel];
      rd_data                      = i_tgt_rd_data[tgt_sel*8 +: 8];
      o_com_rdy                    = i_tgt_com_rdy[tgt_sel] & i_seq_rdy;
      o_block_size = i_tgt_block_size[tgt_sel*`SDIO_DC_BSIZE_W +: `SDIO_DC_BSIZE_W];
    end
  end

  // Return side, PHY silent in command mode
  assign o_cmd_rd_stb   = i_cmd_bus_sel ? rd_stb  : 1'b0;
  assign o_cmd_rd_data  = i_cmd_bus_sel ? rd_data : 8'h00;
  assign o_phy_rd_stb   = i_cmd_bus_sel ? 1'b0    : rd_stb;
  assign o_phy_rd_data  = i_cmd_bus_sel ? 8'h00   : rd_data;
  assign o_phy_com_rdy  = i_cmd_bus_sel ? 1'b0    : o_com_rdy;
  assign o_phy_activate = i_cmd_bus_sel ? 1'b0    : i_phy_activate;

  assign o_xfer_stb = wr_stb | rd_stb;
  assign o_src_rdy  = i_cmd_bus_sel | i_phy_hst_rdy;

  always_comb begin
    assert ($onehot0(o_tgt_wr_stb))
      else $error("ERR router: more than one target write strobe");
  end

endmodule

`default_nettype wire

// File: hw/sdio_dc_pkg.sv
// SDIO data controller types
// Vector typedefs for the datapath and the state encodings of
// the transfer sequencer and the command byte port

`default_nettype none

`include "sdio_dc_params.svh"

package sdio_dc_pkg;
  typedef logic [7:0]                      byte_t;
  typedef logic [`SDIO_DC_ADDR_W-1:0]      sdio_addr_t;
  typedef logic [`SDIO_DC_CNT_W-1:0]       xfer_cnt_t;
  typedef logic [`SDIO_DC_BSIZE_W-1:0]     block_size_t;
  typedef logic [3:0]                      tgt_sel_t;
  typedef logic [`SDIO_DC_NUM_TGT-1:0]     tgt_vec_t;
  // Target lanes packed low to high by target index
  typedef logic [`SDIO_DC_NUM_TGT*8-1:0]   tgt_bytes_t;
  typedef logic [`SDIO_DC_NUM_TGT*`SDIO_DC_BSIZE_W-1:0] tgt_bsize_t;

  typedef enum logic [2:0] {
    XFER_IDLE, XFER_CONFIG, XFER_ACTIVE, XFER_WAIT_PHY, XFER_COOLDOWN, XFER_DONE
  } xfer_state_e;

  typedef enum logic [1:0] {BP_IDLE, BP_WRITE, BP_READ, BP_DONE} byte_port_state_e;
endpackage

`default_nettype wire

// File: hw/sdio_dc_params.svh
// SDIO data controller parameters
// Target counts, datapath widths and timing defaults shared by
// the package and the RTL blocks

`ifndef SDIO_DC_PARAMS_SVH
`define SDIO_DC_PARAMS_SVH

// CIA, functions 1 to 7 and memory
`define SDIO_DC_NUM_TGT        9
`define SDIO_DC_MEM_TGT        8

// Byte-mode count of 0 stands for this many bytes
`define SDIO_DC_DEFAULT_BYTES  512

// Idle cycles between read blocks
`define SDIO_DC_READ_COOLDOWN  400

`define SDIO_DC_ADDR_W         18
`define SDIO_DC_CNT_W          13
`define SDIO_DC_BSIZE_W        16

`endif
